//--- Bender.yml
package:
  name: decode_stage

sources:
  - hw/decode_pkg.sv
  - hw/decode_if.sv
  - hw/inst_decoder.sv
  - hw/hazard_unit.sv
  - hw/stage_ctrl.sv
  - hw/stall_counter.sv
  - hw/operand_fetch.sv
  - hw/decode_stage.sv
  - target: test
    files:
      - dv/decode_stage_tb.sv

//--- dv/decode_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;

	localparam int num_trans        = 3000;
	localparam int cycles_per_trans = 4;
	localparam int timeout_cycles   = 4 * num_trans * cycles_per_trans;

	logic        clock = 1'b0;
	logic        reset;
	logic [31:0] inst;
	logic [31:0] pc;
	logic        in_valid;
	logic        out_ready;
	logic        flush;
	logic        wb_en;
	logic [3:0]  wb_rd;
	logic [31:0] wb_data;
	logic [3:0]  exu_rd;
	logic        exu_reg_wen;
	logic        exu_ready;
	logic [3:0]  lsu_rd;
	logic        lsu_reg_wen;
	logic        lsu_ready;
	logic        in_ready;
	logic        out_valid;
	logic [31:0] out_pc;
	logic [9:0]  class_vec;
	logic [2:0]  funct3;
	logic        funct7_5;
	logic [3:0]  rd;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] imm;
	logic        reg_wen;
	logic        is_ecall;
	logic        is_mret;
	logic        is_fencei;
	logic [31:0] raw_cycles;
	logic [31:0] raw_events;

	logic [31:0] rng_state = 32'h914682d0;
	int          cycle_count = 0;
	int          trans_count = 0;

	// Reference model state.
	logic [31:0] model_regs [0:15];
	logic        model_full;
	logic        model_prev_stall;
	logic [31:0] model_cycles;
	logic [31:0] model_events;
	logic [31:0] exp_pc;
	logic [31:0] exp_src1;
	logic [31:0] exp_src2;
	logic [31:0] exp_imm;
	logic [9:0]  exp_class;
	logic [2:0]  exp_funct3;
	logic [3:0]  exp_rd;
	logic        exp_funct7_5;
	logic        exp_reg_wen;
	logic        exp_ecall;
	logic        exp_mret;
	logic        exp_fencei;

	decode_stage decode_stage_i (.*);

	always #50 clock = ~clock;

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Decode straight from the instruction bit positions.
	task automatic decode_word(
		input  logic [31:0] w,
		output logic [9:0]  cls,
		output logic [31:0] ext_imm,
		output logic        wen,
		output logic        need2
	);
		cls = '0;
		ext_imm = '0;
		case (w[6:0])
			decode_pkg::op_lui:    cls[decode_pkg::inst_lui] = 1'b1;
			decode_pkg::op_auipc:  cls[decode_pkg::inst_auipc] = 1'b1;
			decode_pkg::op_jal:    cls[decode_pkg::inst_jal] = 1'b1;
			decode_pkg::op_jalr:   cls[decode_pkg::inst_jalr] = 1'b1;
			decode_pkg::op_branch: cls[decode_pkg::inst_beq] = 1'b1;
			decode_pkg::op_load:   cls[decode_pkg::inst_lw] = 1'b1;
			decode_pkg::op_store:  cls[decode_pkg::inst_sw] = 1'b1;
			decode_pkg::op_imm:    cls[decode_pkg::inst_addi] = 1'b1;
			decode_pkg::op_reg:    cls[decode_pkg::inst_add] = 1'b1;
			decode_pkg::op_system: cls[decode_pkg::inst_csr] = 1'b1;
			default:               cls = '0;
		endcase
		if (cls[decode_pkg::inst_jalr] | cls[decode_pkg::inst_lw]
				| cls[decode_pkg::inst_addi] | cls[decode_pkg::inst_csr]) begin
			ext_imm = {{20{w[31]}}, w[31:20]};
		end else if (cls[decode_pkg::inst_lui] | cls[decode_pkg::inst_auipc]) begin
			ext_imm = {w[31:12], 12'b0};
		end else if (cls[decode_pkg::inst_sw]) begin
			ext_imm = {{20{w[31]}}, w[31:25], w[11:7]};
		end else if (cls[decode_pkg::inst_jal]) begin
			ext_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end else if (cls[decode_pkg::inst_beq]) begin
			ext_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		end
		// Branch, store and system with funct3 zero leave rd alone.
		wen = (|cls) & ~cls[decode_pkg::inst_beq] & ~cls[decode_pkg::inst_sw]
			& ~(cls[decode_pkg::inst_csr] & (w[14:12] == 3'b0));
		need2 = cls[decode_pkg::inst_beq] | cls[decode_pkg::inst_sw] | cls[decode_pkg::inst_add];
	endtask

	function automatic logic conflict_with(
		input logic [3:0]  unit_rd,
		input logic        unit_wen,
		input logic        unit_ready,
		input logic [31:0] w,
		input logic        need2
	);
		return !unit_ready && unit_wen && (unit_rd != 4'd0)
			&& ((unit_rd == w[18:15]) || (need2 && (unit_rd == w[23:20])));
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Compare with the model, then advance it across the coming edge.
	task automatic check_and_advance();
		logic [9:0]  cls;
		logic [31:0] ext_imm;
		logic        wen;
		logic        need2;
		logic        stall;
		logic        accept;
		decode_word(inst, cls, ext_imm, wen, need2);
		stall = conflict_with(exu_rd, exu_reg_wen, exu_ready, inst, need2)
			| conflict_with(lsu_rd, lsu_reg_wen, lsu_ready, inst, need2);
		check_value("in_ready", !model_full && !stall, in_ready);
		check_value("out_valid", model_full, out_valid);
		check_value("raw_cycles", model_cycles, raw_cycles);
		check_value("raw_events", model_events, raw_events);
		if (model_full) begin
			check_value("out_pc", exp_pc, out_pc);
			check_value("class_vec", exp_class, class_vec);
			check_value("funct3", exp_funct3, funct3);
			check_value("funct7_5", exp_funct7_5, funct7_5);
			check_value("rd", exp_rd, rd);
			check_value("src1", exp_src1, src1);
			check_value("src2", exp_src2, src2);
			check_value("imm", exp_imm, imm);
			check_value("reg_wen", exp_reg_wen, reg_wen);
			check_value("is_ecall", exp_ecall, is_ecall);
			check_value("is_mret", exp_mret, is_mret);
			check_value("is_fencei", exp_fencei, is_fencei);
		end
		if (stall) begin
			model_cycles = model_cycles + 1;
		end
		if (stall && !model_prev_stall) begin
			model_events = model_events + 1;
		end
		model_prev_stall = stall;
		accept = in_valid && !model_full && !stall && !flush;
		if (accept) begin
			exp_pc = pc;
			exp_class = cls;
			exp_funct3 = inst[14:12];
			exp_funct7_5 = inst[30];
			exp_rd = inst[10:7];
			exp_src1 = model_regs[inst[18:15]];
			exp_src2 = model_regs[inst[23:20]];
			exp_imm = ext_imm;
			exp_reg_wen = wen;
			exp_ecall = (inst == 32'h00000073);
			exp_mret = (inst == 32'h30200073);
			exp_fencei = (inst[6:0] == 7'b0001111);
			trans_count++;
		end
		if (flush) begin
			model_full = 1'b0;
		end else if (accept) begin
			model_full = 1'b1;
		end else if (model_full && out_ready) begin
			model_full = 1'b0;
		end
		if (wb_en && (wb_rd != 4'd0)) begin
			model_regs[wb_rd] = wb_data;
		end
	endtask

	task automatic drive_random_inputs();
		decode_pkg::inst_u w;
		logic [31:0]       bits;
		logic [31:0]       r;
		int                pick;
		w = next_random();
		pick = next_random() % 15;
		case (pick)
			0:  w.u_fmt.opcode = decode_pkg::op_lui;
			1:  w.u_fmt.opcode = decode_pkg::op_auipc;
			2:  w.j_fmt.opcode = decode_pkg::op_jal;
			3:  w.i_fmt.opcode = decode_pkg::op_jalr;
			4:  w.b_fmt.opcode = decode_pkg::op_branch;
			5:  w.i_fmt.opcode = decode_pkg::op_load;
			6:  w.s_fmt.opcode = decode_pkg::op_store;
			7:  w.i_fmt.opcode = decode_pkg::op_imm;
			8:  w.r_fmt.opcode = decode_pkg::op_reg;
			9:  w.i_fmt.opcode = decode_pkg::op_system;
			10: w = decode_pkg::ecall_word;
			11: w = decode_pkg::mret_word;
			12: begin
				w.i_fmt.opcode = decode_pkg::op_system;
				w.i_fmt.funct3 = 3'b0;
			end
			13: w.r_fmt.opcode = decode_pkg::op_fence;
			default: ;
		endcase
		bits = w;
		r = next_random();
		inst        <= bits;
		pc          <= next_random() & ~32'h3;
		in_valid    <= (r[1:0] != 2'b00);
		out_ready   <= r[2];
		flush       <= (r[7:3] == 5'd0);
		wb_en       <= r[8];
		// Bias tags toward the sources so conflicts and late writes happen.
		wb_rd       <= r[27] ? bits[18:15] : r[12:9];
		wb_data     <= next_random();
		exu_reg_wen <= r[13];
		exu_ready   <= r[14];
		exu_rd      <= r[17] ? bits[18:15] : r[21:18];
		lsu_reg_wen <= r[15];
		lsu_ready   <= r[16];
		lsu_rd      <= r[22] ? bits[23:20] : r[26:23];
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: %0d transactions not done within %0d cycles",
				num_trans, timeout_cycles);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	initial begin
		for (int i = 0; i < 16; i++) begin
			model_regs[i] = '0;
		end
		model_full = 1'b0;
		model_prev_stall = 1'b0;
		model_cycles = '0;
		model_events = '0;
		reset       <= 1'b1;
		inst        <= '0;
		pc          <= '0;
		in_valid    <= 1'b0;
		out_ready   <= 1'b0;
		flush       <= 1'b0;
		wb_en       <= 1'b0;
		wb_rd       <= '0;
		wb_data     <= '0;
		exu_rd      <= '0;
		exu_reg_wen <= 1'b0;
		exu_ready   <= 1'b1;
		lsu_rd      <= '0;
		lsu_reg_wen <= 1'b0;
		lsu_ready   <= 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		while (trans_count < num_trans) begin
			@(negedge clock);
			check_and_advance();
			@(posedge clock);
			drive_random_inputs();
		end
		// The last accepted item is held from here on.
		@(negedge clock);
		check_and_advance();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/decode_if.sv
`timescale 1ns/10ps
`default_nettype none

interface decode_if;

	logic [decode_pkg::num_inst-1:0]   class_vec;
	logic [2:0]                        funct3;
	logic                              funct7_5;
	logic [decode_pkg::reg_addr_w-1:0] rd;
	logic [decode_pkg::reg_addr_w-1:0] rs1;
	logic [decode_pkg::reg_addr_w-1:0] rs2;
	logic                              need_rs2;
	logic [decode_pkg::xlen-1:0]       imm;
	logic                              reg_wen;
	logic                              is_ecall;
	logic                              is_mret;
	logic                              is_fencei;

	modport producer (
		output class_vec, funct3, funct7_5, rd, rs1, rs2, need_rs2,
		output imm, reg_wen, is_ecall, is_mret, is_fencei
	);

	modport hazard (
		input rs1, rs2, need_rs2
	);

	modport stage (
		input class_vec, funct3, funct7_5, rd, rs1, rs2, need_rs2,
		input imm, reg_wen, is_ecall, is_mret, is_fencei
	);

endinterface

`default_nettype wire

//--- hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

	localparam int reg_count  = 16;
	localparam int reg_addr_w = 4;
	localparam int xlen       = 32;
	localparam int num_inst   = 10;
	localparam int counter_w  = 32;

	// Bit positions in the one-hot class vector.
	localparam int inst_lui   = 0;
	localparam int inst_auipc = 1;
	localparam int inst_jal   = 2;
	localparam int inst_jalr  = 3;
	localparam int inst_beq   = 4;
	localparam int inst_lw    = 5;
	localparam int inst_sw    = 6;
	localparam int inst_addi  = 7;
	localparam int inst_add   = 8;
	localparam int inst_csr   = 9;

	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;
	localparam logic [6:0] op_fence  = 7'b0001111;

	localparam logic [31:0] ecall_word = 32'h00000073;
	localparam logic [31:0] mret_word  = 32'h30200073;

	localparam logic st_ready = 1'b0;
	localparam logic st_full  = 1'b1;

	// One word, six field layouts; all share the low opcode.
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm_12;
			logic [5:0] imm_10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm_4_1;
			logic       imm_11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_u;

endpackage

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  logic                             clock,
	input  logic                             reset,
	input  logic [decode_pkg::xlen-1:0]       inst,
	input  logic [decode_pkg::xlen-1:0]       pc,
	input  logic                             in_valid,
	input  logic                             out_ready,
	input  logic                             flush,
	input  logic                             wb_en,
	input  logic [decode_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [decode_pkg::xlen-1:0]       wb_data,
	input  logic [decode_pkg::reg_addr_w-1:0] exu_rd,
	input  logic                             exu_reg_wen,
	input  logic                             exu_ready,
	input  logic [decode_pkg::reg_addr_w-1:0] lsu_rd,
	input  logic                             lsu_reg_wen,
	input  logic                             lsu_ready,
	output logic                             in_ready,
	output logic                             out_valid,
	output logic [decode_pkg::xlen-1:0]       out_pc,
	output logic [decode_pkg::num_inst-1:0]   class_vec,
	output logic [2:0]                       funct3,
	output logic                             funct7_5,
	output logic [decode_pkg::reg_addr_w-1:0] rd,
	output logic [decode_pkg::xlen-1:0]       src1,
	output logic [decode_pkg::xlen-1:0]       src2,
	output logic [decode_pkg::xlen-1:0]       imm,
	output logic                             reg_wen,
	output logic                             is_ecall,
	output logic                             is_mret,
	output logic                             is_fencei,
	output logic [decode_pkg::counter_w-1:0]  raw_cycles,
	output logic [decode_pkg::counter_w-1:0]  raw_events
);

	logic stall;
	logic load;

	decode_if dec_if ();

	inst_decoder inst_decoder_i (
		.inst (inst),
		.dec  (dec_if.producer)
	);

	hazard_unit hazard_unit_i (
		.dec         (dec_if.hazard),
		.exu_rd      (exu_rd),
		.exu_reg_wen (exu_reg_wen),
		.exu_ready   (exu_ready),
		.lsu_rd      (lsu_rd),
		.lsu_reg_wen (lsu_reg_wen),
		.lsu_ready   (lsu_ready),
		.stall       (stall)
	);

	stage_ctrl stage_ctrl_i (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (in_valid),
		.stall     (stall),
		.out_ready (out_ready),
		.flush     (flush),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.load      (load)
	);

	stall_counter stall_counter_i (
		.clock      (clock),
		.reset      (reset),
		.stall      (stall),
		.raw_cycles (raw_cycles),
		.raw_events (raw_events)
	);

	operand_fetch operand_fetch_i (
		.clock     (clock),
		.reset     (reset),
		.load      (load),
		.dec       (dec_if.stage),
		.pc        (pc),
		.wb_en     (wb_en),
		.wb_rd     (wb_rd),
		.wb_data   (wb_data),
		.out_pc    (out_pc),
		.class_vec (class_vec),
		.funct3    (funct3),
		.funct7_5  (funct7_5),
		.rd        (rd),
		.src1      (src1),
		.src2      (src2),
		.imm       (imm),
		.reg_wen   (reg_wen),
		.is_ecall  (is_ecall),
		.is_mret   (is_mret),
		.is_fencei (is_fencei)
	);

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	decode_if.hazard                         dec,
	input  logic [decode_pkg::reg_addr_w-1:0] exu_rd,
	input  logic                             exu_reg_wen,
	input  logic                             exu_ready,
	input  logic [decode_pkg::reg_addr_w-1:0] lsu_rd,
	input  logic                             lsu_reg_wen,
	input  logic                             lsu_ready,
	output logic                             stall
);

	// A busy unit about to write a live source register.
	function automatic logic unit_conflict(
		input logic [decode_pkg::reg_addr_w-1:0] unit_rd,
		input logic                             unit_wen,
		input logic                             unit_ready
	);
		logic rd_live;
		rd_live = ~unit_ready & unit_wen & (unit_rd != '0);
		return rd_live & ((unit_rd == dec.rs1) | (dec.need_rs2 & (unit_rd == dec.rs2)));
	endfunction

	assign stall = unit_conflict(exu_rd, exu_reg_wen, exu_ready)
		| unit_conflict(lsu_rd, lsu_reg_wen, lsu_ready);

endmodule

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
	input  logic [decode_pkg::xlen-1:0] inst,
	decode_if.producer                  dec
);

	decode_pkg::inst_u              word;
	logic [decode_pkg::num_inst-1:0] cls;
	logic                           fmt_r;
	logic                           fmt_i;
	logic                           fmt_s;
	logic                           fmt_b;
	logic                           fmt_u;
	logic                           fmt_j;

	assign word = inst;

	assign cls[decode_pkg::inst_lui]   = (word.r_fmt.opcode == decode_pkg::op_lui);
	assign cls[decode_pkg::inst_auipc] = (word.r_fmt.opcode == decode_pkg::op_auipc);
	assign cls[decode_pkg::inst_jal]   = (word.r_fmt.opcode == decode_pkg::op_jal);
	assign cls[decode_pkg::inst_jalr]  = (word.r_fmt.opcode == decode_pkg::op_jalr);
	assign cls[decode_pkg::inst_beq]   = (word.r_fmt.opcode == decode_pkg::op_branch);
	assign cls[decode_pkg::inst_lw]    = (word.r_fmt.opcode == decode_pkg::op_load);
	assign cls[decode_pkg::inst_sw]    = (word.r_fmt.opcode == decode_pkg::op_store);
	assign cls[decode_pkg::inst_addi]  = (word.r_fmt.opcode == decode_pkg::op_imm);
	assign cls[decode_pkg::inst_add]   = (word.r_fmt.opcode == decode_pkg::op_reg);
	assign cls[decode_pkg::inst_csr]   = (word.r_fmt.opcode == decode_pkg::op_system);

	// Format from class.
	assign fmt_r = cls[decode_pkg::inst_add];
	assign fmt_i = cls[decode_pkg::inst_jalr] | cls[decode_pkg::inst_lw]
		| cls[decode_pkg::inst_addi] | cls[decode_pkg::inst_csr];
	assign fmt_s = cls[decode_pkg::inst_sw];
	assign fmt_b = cls[decode_pkg::inst_beq];
	assign fmt_u = cls[decode_pkg::inst_lui] | cls[decode_pkg::inst_auipc];
	assign fmt_j = cls[decode_pkg::inst_jal];

	always_comb begin
		if (fmt_i) begin
			dec.imm = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
		end else if (fmt_u) begin
			dec.imm = {word.u_fmt.imm, 12'b0};
		end else if (fmt_s) begin
			dec.imm = {{20{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi, word.s_fmt.imm_lo};
		end else if (fmt_j) begin
			dec.imm = {{12{word.j_fmt.imm_20}}, word.j_fmt.imm_19_12, word.j_fmt.imm_11,
				word.j_fmt.imm_10_1, 1'b0};
		end else if (fmt_b) begin
			dec.imm = {{20{word.b_fmt.imm_12}}, word.b_fmt.imm_11, word.b_fmt.imm_10_5,
				word.b_fmt.imm_4_1, 1'b0};
		end else begin
			dec.imm = '0;
		end
	end

	assign dec.class_vec = cls;
	assign dec.funct3    = word.r_fmt.funct3;
	assign dec.funct7_5  = word.r_fmt.funct7[5];
	// RV32E uses only the low four bits of each register field.
	assign dec.rd        = word.r_fmt.rd[decode_pkg::reg_addr_w-1:0];
	assign dec.rs1       = word.r_fmt.rs1[decode_pkg::reg_addr_w-1:0];
	assign dec.rs2       = word.r_fmt.rs2[decode_pkg::reg_addr_w-1:0];
	assign dec.need_rs2  = cls[decode_pkg::inst_beq] | cls[decode_pkg::inst_sw]
		| cls[decode_pkg::inst_add];

	// CSR ops write rd; ecall, mret and friends do not.
	assign dec.reg_wen = (fmt_i & ~(cls[decode_pkg::inst_csr] & (word.i_fmt.funct3 == 3'b0)))
		| fmt_u | fmt_j | fmt_r;

	assign dec.is_ecall  = (inst == decode_pkg::ecall_word);
	assign dec.is_mret   = (inst == decode_pkg::mret_word);
	assign dec.is_fencei = (word.r_fmt.opcode == decode_pkg::op_fence);

endmodule

`default_nettype wire

//--- hw/operand_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module operand_fetch (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             load,
	decode_if.stage                          dec,
	input  logic [decode_pkg::xlen-1:0]       pc,
	input  logic                             wb_en,
	input  logic [decode_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [decode_pkg::xlen-1:0]       wb_data,
	output logic [decode_pkg::xlen-1:0]       out_pc,
	output logic [decode_pkg::num_inst-1:0]   class_vec,
	output logic [2:0]                       funct3,
	output logic                             funct7_5,
	output logic [decode_pkg::reg_addr_w-1:0] rd,
	output logic [decode_pkg::xlen-1:0]       src1,
	output logic [decode_pkg::xlen-1:0]       src2,
	output logic [decode_pkg::xlen-1:0]       imm,
	output logic                             reg_wen,
	output logic                             is_ecall,
	output logic                             is_mret,
	output logic                             is_fencei
);

	logic [decode_pkg::xlen-1:0] regs [1:decode_pkg::reg_count-1];
	logic [decode_pkg::xlen-1:0] rdata1;
	logic [decode_pkg::xlen-1:0] rdata2;

	// x0 is hardwired to zero.
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < decode_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && (wb_rd != '0)) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// No write-through; a same-cycle write shows up next cycle.
	assign rdata1 = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
	assign rdata2 = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

	always_ff @(posedge clock) begin
		if (load) begin
			out_pc    <= pc;
			class_vec <= dec.class_vec;
			funct3    <= dec.funct3;
			funct7_5  <= dec.funct7_5;
			rd        <= dec.rd;
			src1      <= rdata1;
			src2      <= rdata2;
			imm       <= dec.imm;
			reg_wen   <= dec.reg_wen;
			is_ecall  <= dec.is_ecall;
			is_mret   <= dec.is_mret;
			is_fencei <= dec.is_fencei;
		end
	end

endmodule

`default_nettype wire

//--- hw/stage_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module stage_ctrl (
	input  logic clock,
	input  logic reset,
	input  logic in_valid,
	input  logic stall,
	input  logic out_ready,
	input  logic flush,
	output logic in_ready,
	output logic out_valid,
	output logic load
);

	logic state;

	assign in_ready  = (state == decode_pkg::st_ready) & ~stall;
	assign out_valid = (state == decode_pkg::st_full);
	assign load      = in_valid & ~stall & (state == decode_pkg::st_ready) & ~flush;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= decode_pkg::st_ready;
		end else if (flush) begin
			state <= decode_pkg::st_ready;
		end else begin
			case (state)
				decode_pkg::st_ready: begin
					if (load) begin
						state <= decode_pkg::st_full;
					end
				end
				default: begin
					// Single slot, so a consume only frees it.
					if (out_ready) begin
						state <= decode_pkg::st_ready;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/stall_counter.sv
`timescale 1ns/10ps
`default_nettype none

module stall_counter (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            stall,
	output logic [decode_pkg::counter_w-1:0] raw_cycles,
	output logic [decode_pkg::counter_w-1:0] raw_events
);

	logic stall_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			stall_q    <= 1'b0;
			raw_cycles <= '0;
			raw_events <= '0;
		end else begin
			stall_q <= stall;
			if (stall) begin
				raw_cycles <= raw_cycles + 1'b1;
			end
			// New conflict starts.
			if (stall & ~stall_q) begin
				raw_events <= raw_events + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- list.f
hw/decode_pkg.sv
hw/decode_if.sv
hw/inst_decoder.sv
hw/hazard_unit.sv
hw/stage_ctrl.sv
hw/stall_counter.sv
hw/operand_fetch.sv
hw/decode_stage.sv
dv/decode_stage_tb.sv
